//--- tcm_pkg.sv
// Shared constants for the DTCM controller
// RAM size is fixed by RAM_AW, and RAM_BYTES must equal 4 << RAM_AW
// RSP_DEPTH must be a power of two, so the queue pointers wrap on their own
// The byte address is wider than the RAM, and the top part only feeds the range check

package tcm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data path widths
  localparam int XLEN    = 32;
  localparam int WMASK_W = XLEN / 8;      // One enable per byte lane

  //////////////////////////////////////////////////////////////////////
  // Address space
  localparam int ADDR_W    = 16;          // Byte address on both ICB ports
  localparam int RAM_AW    = 10;          // Word address into the SRAM
  localparam int RAM_BYTES = 4096;

  //////////////////////////////////////////////////////////////////////
  // Access owner, carried down the pipe with every command
  localparam logic OWNER_LSU = 1'b0;
  localparam logic OWNER_EXT = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Response queue

  localparam int RSP_DEPTH = 2;
  localparam int PTR_W     = $clog2(RSP_DEPTH);
  // Count range is 0..RSP_DEPTH, so one extra bit over the pointers
  localparam int CNT_W     = $clog2(RSP_DEPTH + 1);

endpackage

//--- tcm_if.sv
// Internal links between the pipeline stages of the DTCM controller
// Command link uses valid/ready, response link is a push with credit
// Links to the SRAM are plain strobes, with read data one cycle later

`timescale 1ns/1ps

// Granted command, arbiter to RAM access stage
interface tcm_cmd_if import tcm_pkg::*; ();
  logic              valid;
  logic              ready;
  logic [ADDR_W-1:0] addr;
  logic              read;
  logic [XLEN-1:0]   wdata;
  logic [WMASK_W-1:0] wmask;
  logic              owner;

  modport arb (output valid, addr, read, wdata, wmask, owner, input ready);
  modport acc (input valid, addr, read, wdata, wmask, owner, output ready);
endinterface

// Completed access, RAM access stage to response queue
interface tcm_rsp_if import tcm_pkg::*; ();
  logic             valid;   // One-cycle push, no ready
  logic [XLEN-1:0]  rdata;
  logic             err;
  logic             owner;
  logic [CNT_W-1:0] space;   // Free queue entries

  modport acc  (output valid, rdata, err, owner, input space);
  modport rbuf (input valid, rdata, err, owner, output space);
endinterface

// SRAM macro port
interface tcm_ram_if import tcm_pkg::*; ();
  logic               cs;
  logic               we;
  logic [RAM_AW-1:0]  addr;
  logic [WMASK_W-1:0] wem;
  logic [XLEN-1:0]    din;
  logic [XLEN-1:0]    dout;

  modport ctl (output cs, we, addr, wem, din, input dout);
  modport mem (input cs, we, addr, wem, din, output dout);
endinterface

//--- tcm_icb_arbiter.sv
// Round-robin arbiter for the LSU and external-agent ICB command channels
// Grant is combinational. A request that waits on ready keeps its grant,
// so masters must hold valid and fields until the transfer
// After reset the external port counts as last granted

`timescale 1ns/1ps

module tcm_icb_arbiter import tcm_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               lsu_cmd_valid,
  output logic               lsu_cmd_ready,
  input  logic [ADDR_W-1:0]  lsu_cmd_addr,
  input  logic               lsu_cmd_read,
  input  logic [XLEN-1:0]    lsu_cmd_wdata,
  input  logic [WMASK_W-1:0] lsu_cmd_wmask,

  input  logic               ext_cmd_valid,
  output logic               ext_cmd_ready,
  input  logic [ADDR_W-1:0]  ext_cmd_addr,
  input  logic               ext_cmd_read,
  input  logic [XLEN-1:0]    ext_cmd_wdata,
  input  logic [WMASK_W-1:0] ext_cmd_wmask,

  tcm_cmd_if.arb             cmd
);

  logic last_ext;   // Port granted on the last transfer
  logic locked;     // Previous cycle stalled with a grant out
  logic lock_ext;
  logic rr_ext;
  logic grant_ext;

  // Prefer ext unless lsu also asks and ext went last
  assign rr_ext    = ext_cmd_valid & (~lsu_cmd_valid | ~last_ext);
  assign grant_ext = locked ? lock_ext : rr_ext;

  assign cmd.valid = lsu_cmd_valid | ext_cmd_valid;
  assign cmd.addr  = grant_ext ? ext_cmd_addr  : lsu_cmd_addr;
  assign cmd.read  = grant_ext ? ext_cmd_read  : lsu_cmd_read;
  assign cmd.wdata = grant_ext ? ext_cmd_wdata : lsu_cmd_wdata;
  assign cmd.wmask = grant_ext ? ext_cmd_wmask : lsu_cmd_wmask;
  assign cmd.owner = grant_ext ? OWNER_EXT : OWNER_LSU;

  assign lsu_cmd_ready = cmd.ready & ~grant_ext;
  assign ext_cmd_ready = cmd.ready &  grant_ext;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_ext <= 1'b1;
      locked   <= 1'b0;
      lock_ext <= 1'b0;
    end else begin
      locked   <= cmd.valid & ~cmd.ready;   // Freeze grant across a stall
      lock_ext <= grant_ext;
      if (cmd.valid && cmd.ready) begin
        last_ext <= grant_ext;
      end
    end
  end

endmodule

//--- tcm_ram_access.sv
// RAM access stage of the DTCM controller
// Accepts a command only while the response queue has a free entry left
// after counting the access still in flight. The SRAM is strobed on the
// accepting edge, and the result is pushed into the queue one cycle later
// Out-of-range addresses never touch the SRAM and return err with zero data

`timescale 1ns/1ps

module tcm_ram_access import tcm_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  tcm_cmd_if.acc cmd,
  tcm_rsp_if.acc rsp,
  tcm_ram_if.ctl ram
);

  logic accept;
  logic in_range;

  // Access between SRAM strobe and queue push
  logic pend_vld;
  logic pend_err;
  logic pend_read;
  logic pend_owner;

  //////////////////////////////////////////////////////////////////////
  // Command side

  // Credit check, the pending access already owns one free entry
  assign cmd.ready = rsp.space > CNT_W'(pend_vld);
  assign accept    = cmd.valid & cmd.ready;
  assign in_range  = cmd.addr < ADDR_W'(RAM_BYTES);

  assign ram.cs   = accept & in_range;
  assign ram.we   = ~cmd.read;
  assign ram.addr = cmd.addr[RAM_AW+1:2];   // Word address
  assign ram.wem  = cmd.wmask;
  assign ram.din  = cmd.wdata;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_vld <= 1'b0;
    end else begin
      pend_vld <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pend_err   <= ~in_range;
      pend_read  <= cmd.read;
      pend_owner <= cmd.owner;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response push

  assign rsp.valid = pend_vld;
  assign rsp.err   = pend_err;
  assign rsp.owner = pend_owner;
  assign rsp.rdata = (pend_read && !pend_err) ? ram.dout : '0;   // Zero for writes

endmodule

//--- tcm_sram.sv
// Single-port word SRAM model with byte write enables
// Read data is registered and holds until the next read
// A write does not update dout. Contents are undefined after power-up

`timescale 1ns/1ps

module tcm_sram import tcm_pkg::*; (
  input  logic   clk,
  tcm_ram_if.mem ram
);

  logic [XLEN-1:0] mem [0:(1 << RAM_AW)-1];

  always_ff @(posedge clk) begin
    if (ram.cs && ram.we) begin
      for (int i = 0; i < WMASK_W; i++) begin
        if (ram.wem[i]) begin
          mem[ram.addr][i*8 +: 8] <= ram.din[i*8 +: 8];   // Enabled lanes only
        end
      end
    end
    if (ram.cs && !ram.we) begin
      ram.dout <= mem[ram.addr];
    end
  end

endmodule

//--- tcm_rsp_buffer.sv
// Response queue of the DTCM controller
// Entries leave in push order. The head entry is shown only on the channel
// of the port that issued it, so a waiting entry for one port blocks the
// other port's responses behind it
// No overflow guard, the RAM access stage pushes only against a credit

`timescale 1ns/1ps

module tcm_rsp_buffer import tcm_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  tcm_rsp_if.rbuf         rsp,

  output logic            lsu_rsp_valid,
  input  logic            lsu_rsp_ready,
  output logic            lsu_rsp_err,
  output logic [XLEN-1:0] lsu_rsp_rdata,

  output logic            ext_rsp_valid,
  input  logic            ext_rsp_ready,
  output logic            ext_rsp_err,
  output logic [XLEN-1:0] ext_rsp_rdata
);

  logic [XLEN-1:0]  ent_rdata [RSP_DEPTH];
  logic             ent_err   [RSP_DEPTH];
  logic             ent_owner [RSP_DEPTH];

  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [CNT_W-1:0] count;
  logic             not_empty;
  logic             pop;

  assign not_empty = count != '0;
  assign rsp.space = CNT_W'(RSP_DEPTH) - count;   // Credit back to RAM access

  //////////////////////////////////////////////////////////////////////
  // Head entry steered to its owner

  assign lsu_rsp_valid = not_empty & (ent_owner[rptr] == OWNER_LSU);
  assign ext_rsp_valid = not_empty & (ent_owner[rptr] == OWNER_EXT);
  assign lsu_rsp_err   = ent_err[rptr];
  assign ext_rsp_err   = ent_err[rptr];
  assign lsu_rsp_rdata = ent_rdata[rptr];
  assign ext_rsp_rdata = ent_rdata[rptr];

  assign pop = (lsu_rsp_valid & lsu_rsp_ready) | (ext_rsp_valid & ext_rsp_ready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (rsp.valid) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      count <= count + CNT_W'(rsp.valid) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (rsp.valid) begin
      ent_rdata[wptr] <= rsp.rdata;
      ent_err[wptr]   <= rsp.err;
      ent_owner[wptr] <= rsp.owner;
    end
  end

endmodule

//--- tcm_ctrl_top.sv
// DTCM controller, two ICB masters sharing one 4 KB SRAM
// Round-robin between LSU and external agent, in-order responses
// Best-case latency is two edges from command accept to rsp_valid
// At most RSP_DEPTH accesses are in flight or waiting at any time
// Commands must hold valid and fields until accepted

`timescale 1ns/1ps

module tcm_ctrl_top import tcm_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,

  // LSU port
  input  logic               lsu_cmd_valid,
  output logic               lsu_cmd_ready,
  input  logic [ADDR_W-1:0]  lsu_cmd_addr,
  input  logic               lsu_cmd_read,
  input  logic [XLEN-1:0]    lsu_cmd_wdata,
  input  logic [WMASK_W-1:0] lsu_cmd_wmask,
  output logic               lsu_rsp_valid,
  input  logic               lsu_rsp_ready,
  output logic               lsu_rsp_err,
  output logic [XLEN-1:0]    lsu_rsp_rdata,

  // External agent port
  input  logic               ext_cmd_valid,
  output logic               ext_cmd_ready,
  input  logic [ADDR_W-1:0]  ext_cmd_addr,
  input  logic               ext_cmd_read,
  input  logic [XLEN-1:0]    ext_cmd_wdata,
  input  logic [WMASK_W-1:0] ext_cmd_wmask,
  output logic               ext_rsp_valid,
  input  logic               ext_rsp_ready,
  output logic               ext_rsp_err,
  output logic [XLEN-1:0]    ext_rsp_rdata
);

  tcm_cmd_if u_cmd_if ();
  tcm_rsp_if u_rsp_if ();
  tcm_ram_if u_ram_if ();

  //////////////////////////////////////////////////////////////////////
  // Command path

  tcm_icb_arbiter u_arbiter (
    .clk           (clk          ),
    .rst_n         (rst_n        ),
    .lsu_cmd_valid (lsu_cmd_valid),
    .lsu_cmd_ready (lsu_cmd_ready),
    .lsu_cmd_addr  (lsu_cmd_addr ),
    .lsu_cmd_read  (lsu_cmd_read ),
    .lsu_cmd_wdata (lsu_cmd_wdata),
    .lsu_cmd_wmask (lsu_cmd_wmask),
    .ext_cmd_valid (ext_cmd_valid),
    .ext_cmd_ready (ext_cmd_ready),
    .ext_cmd_addr  (ext_cmd_addr ),
    .ext_cmd_read  (ext_cmd_read ),
    .ext_cmd_wdata (ext_cmd_wdata),
    .ext_cmd_wmask (ext_cmd_wmask),
    .cmd           (u_cmd_if.arb )
  );

  tcm_ram_access u_ram_access (
    .clk   (clk         ),
    .rst_n (rst_n       ),
    .cmd   (u_cmd_if.acc),
    .rsp   (u_rsp_if.acc),
    .ram   (u_ram_if.ctl)
  );

  tcm_sram u_sram (
    .clk (clk         ),
    .ram (u_ram_if.mem)
  );

  //////////////////////////////////////////////////////////////////////
  // Response path

  tcm_rsp_buffer u_rsp_buffer (
    .clk           (clk          ),
    .rst_n         (rst_n        ),
    .rsp           (u_rsp_if.rbuf),
    .lsu_rsp_valid (lsu_rsp_valid),
    .lsu_rsp_ready (lsu_rsp_ready),
    .lsu_rsp_err   (lsu_rsp_err  ),
    .lsu_rsp_rdata (lsu_rsp_rdata),
    .ext_rsp_valid (ext_rsp_valid),
    .ext_rsp_ready (ext_rsp_ready),
    .ext_rsp_err   (ext_rsp_err  ),
    .ext_rsp_rdata (ext_rsp_rdata)
  );

endmodule

//--- tb_tcm_ctrl.sv
// Directed testbench for the DTCM controller
// A reference memory predicts read data with the byte mask rule
// Words are checked only after they have been written in full
// Streaming tests read from 0x0300 (LSU) and 0x0380 (external port)

`timescale 1ns/1ps

module tb_tcm_ctrl import tcm_pkg::*; ();

  logic               clk;
  logic               rst_n;
  logic               lsu_cmd_valid, lsu_cmd_ready, lsu_cmd_read;
  logic [ADDR_W-1:0]  lsu_cmd_addr;
  logic [XLEN-1:0]    lsu_cmd_wdata;
  logic [WMASK_W-1:0] lsu_cmd_wmask;
  logic               lsu_rsp_valid, lsu_rsp_ready, lsu_rsp_err;
  logic [XLEN-1:0]    lsu_rsp_rdata;
  logic               ext_cmd_valid, ext_cmd_ready, ext_cmd_read;
  logic [ADDR_W-1:0]  ext_cmd_addr;
  logic [XLEN-1:0]    ext_cmd_wdata;
  logic [WMASK_W-1:0] ext_cmd_wmask;
  logic               ext_rsp_valid, ext_rsp_ready, ext_rsp_err;
  logic [XLEN-1:0]    ext_rsp_rdata;

  logic [XLEN-1:0] ref_mem [0:(1 << RAM_AW)-1];
  int              errors;

  tcm_ctrl_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Watchdog at about ten times the length of all tests together
  initial begin
    repeat (3000) @(posedge clk);
    $display("Timeout: the tests did not finish within 3000 clock cycles");
    $display("Errors found");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic check_word(input string name, input logic [XLEN-1:0] act,
                            input logic [XLEN-1:0] exp);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, exp, act);
    end
  endtask

  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old,
      input logic [XLEN-1:0] wdata, input logic [WMASK_W-1:0] wmask);
    logic [XLEN-1:0] res;
    res = old;
    for (int i = 0; i < WMASK_W; i++) begin
      if (wmask[i]) begin
        res[i*8 +: 8] = wdata[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // One command on one port, then wait for its response
  task automatic single_access(input logic port, input logic [ADDR_W-1:0] addr,
      input logic read, input logic [XLEN-1:0] wdata, input logic [WMASK_W-1:0] wmask);
    logic            exp_err;
    logic [XLEN-1:0] exp_rdata;
    exp_err   = addr >= RAM_BYTES;
    exp_rdata = '0;
    if (!exp_err && read) begin
      exp_rdata = ref_mem[addr[RAM_AW+1:2]];
    end
    if (!exp_err && !read) begin
      ref_mem[addr[RAM_AW+1:2]] = merge_bytes(ref_mem[addr[RAM_AW+1:2]], wdata, wmask);
    end
    @(posedge clk);
    if (port == OWNER_LSU) begin
      lsu_cmd_valid <= 1'b1;
      lsu_cmd_addr  <= addr;
      lsu_cmd_read  <= read;
      lsu_cmd_wdata <= wdata;
      lsu_cmd_wmask <= wmask;
    end else begin
      ext_cmd_valid <= 1'b1;
      ext_cmd_addr  <= addr;
      ext_cmd_read  <= read;
      ext_cmd_wdata <= wdata;
      ext_cmd_wmask <= wmask;
    end
    @(posedge clk);
    while (!(port == OWNER_LSU ? lsu_cmd_ready : ext_cmd_ready)) @(posedge clk);
    lsu_cmd_valid <= 1'b0;
    ext_cmd_valid <= 1'b0;
    @(posedge clk);
    while (!(port == OWNER_LSU ? lsu_rsp_valid : ext_rsp_valid)) @(posedge clk);
    if (port == OWNER_LSU) begin
      check_word("lsu_rsp_err", lsu_rsp_err, exp_err);
      if (!$isunknown(exp_rdata)) begin
        check_word("lsu_rsp_rdata", lsu_rsp_rdata, exp_rdata);
      end
    end else begin
      check_word("ext_rsp_err", ext_rsp_err, exp_err);
      if (!$isunknown(exp_rdata)) begin
        check_word("ext_rsp_rdata", ext_rsp_rdata, exp_rdata);
      end
    end
  endtask

  task automatic lsu_access(input logic [ADDR_W-1:0] addr, input logic read,
      input logic [XLEN-1:0] wdata, input logic [WMASK_W-1:0] wmask);
    single_access(OWNER_LSU, addr, read, wdata, wmask);
  endtask

  task automatic ext_access(input logic [ADDR_W-1:0] addr, input logic read,
      input logic [XLEN-1:0] wdata, input logic [WMASK_W-1:0] wmask);
    single_access(OWNER_EXT, addr, read, wdata, wmask);
  endtask

  // Both ports stream n reads while rsp_ready is low for the first hold cycles
  task automatic stream_reads(input int n, input int hold);
    logic            exp_port [$];
    logic [XLEN-1:0] exp_data [$];
    int              li;
    int              ei;
    int              cyc;
    int              n_acc;
    logic            last_port;
    logic            rsp_port;
    bit              have_last;
    li        = 0;
    ei        = 0;
    cyc       = 0;
    n_acc     = 0;
    have_last = 0;
    @(posedge clk);
    lsu_cmd_valid <= 1'b1;
    lsu_cmd_read  <= 1'b1;
    lsu_cmd_addr  <= 16'h0300;
    ext_cmd_valid <= 1'b1;
    ext_cmd_read  <= 1'b1;
    ext_cmd_addr  <= 16'h0380;
    lsu_rsp_ready <= (hold == 0);
    ext_rsp_ready <= (hold == 0);
    while (li < n || ei < n || exp_port.size() > 0) begin
      @(posedge clk);
      cyc++;
      rsp_port = ext_rsp_valid;
      if ((lsu_rsp_valid && lsu_rsp_ready) || (ext_rsp_valid && ext_rsp_ready)) begin
        if (exp_port.size() == 0 || exp_port[0] != rsp_port) begin
          errors++;
          $display("A response arrived on the wrong port or out of acceptance order");
        end else begin
          check_word(rsp_port ? "ext_rsp_rdata" : "lsu_rsp_rdata",
                     rsp_port ? ext_rsp_rdata : lsu_rsp_rdata, exp_data[0]);
          check_word(rsp_port ? "ext_rsp_err" : "lsu_rsp_err",
                     rsp_port ? ext_rsp_err : lsu_rsp_err, '0);
        end
        if (exp_port.size() > 0) begin
          void'(exp_port.pop_front());
          void'(exp_data.pop_front());
        end
      end
      if (lsu_cmd_valid && lsu_cmd_ready) begin
        if (have_last && last_port == OWNER_LSU && ext_cmd_valid) begin
          errors++;
          $display("The LSU port was granted twice in a row while the external port waited");
        end
        exp_port.push_back(OWNER_LSU);
        exp_data.push_back(ref_mem[lsu_cmd_addr[RAM_AW+1:2]]);
        last_port = OWNER_LSU;
        have_last = 1;
        n_acc++;
        li++;
        if (li < n) begin
          lsu_cmd_addr <= ADDR_W'(16'h0300 + 4 * li);
        end else begin
          lsu_cmd_valid <= 1'b0;
        end
      end
      if (ext_cmd_valid && ext_cmd_ready) begin
        if (have_last && last_port == OWNER_EXT && lsu_cmd_valid) begin
          errors++;
          $display("The external port was granted twice in a row while the LSU port waited");
        end
        exp_port.push_back(OWNER_EXT);
        exp_data.push_back(ref_mem[ext_cmd_addr[RAM_AW+1:2]]);
        last_port = OWNER_EXT;
        have_last = 1;
        n_acc++;
        ei++;
        if (ei < n) begin
          ext_cmd_addr <= ADDR_W'(16'h0380 + 4 * ei);
        end else begin
          ext_cmd_valid <= 1'b0;
        end
      end
      if (hold > 0 && cyc == hold) begin   // End of the back-pressure window
        if (n_acc != RSP_DEPTH) begin
          errors++;
          $display("%0d commands were accepted under back-pressure, %0d expected",
                   n_acc, RSP_DEPTH);
        end
        if (lsu_cmd_ready || ext_cmd_ready) begin
          errors++;
          $display("A cmd_ready output stayed high while the response queue was full");
        end
        lsu_rsp_ready <= 1'b1;
        ext_rsp_ready <= 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests

  task automatic check_reset_state();
    if (lsu_rsp_valid !== 1'b0 || ext_rsp_valid !== 1'b0) begin
      errors++;
      $display("A response valid output is not low after reset");
    end
    lsu_access(16'h0100, 1'b1, '0, '0);   // Unwritten word with no known data
  endtask

  task automatic lsu_masked_rw();
    for (int i = 0; i < 8; i++) begin
      lsu_access(ADDR_W'(16'h0040 + 4 * i), 1'b0, $urandom, 4'hF);
      lsu_access(ADDR_W'(16'h0040 + 4 * i), 1'b0, $urandom, WMASK_W'($urandom));
      lsu_access(ADDR_W'(16'h0040 + 4 * i), 1'b1, '0, '0);
    end
  endtask

  task automatic cross_port_rw();
    ext_access(16'h0200, 1'b0, $urandom, 4'hF);
    lsu_access(16'h0200, 1'b1, '0, '0);
    lsu_access(16'h0204, 1'b0, $urandom, 4'hF);
    ext_access(16'h0204, 1'b1, '0, '0);
  endtask

  task automatic out_of_range();
    ext_access(16'h0000, 1'b0, $urandom, 4'hF);   // Word 0 is the alias of 0x1000
    lsu_access(16'h1040, 1'b0, $urandom, 4'hF);   // Would alias word 0x0040
    ext_access(16'hFFFC, 1'b1, '0, '0);
    ext_access(16'h1000, 1'b0, $urandom, 4'hF);
    lsu_access(16'h1000, 1'b1, '0, '0);
    lsu_access(16'h0040, 1'b1, '0, '0);
    ext_access(16'h0000, 1'b1, '0, '0);
  endtask

  task automatic round_robin();
    for (int i = 0; i < 8; i++) begin
      lsu_access(ADDR_W'(16'h0300 + 4 * i), 1'b0, $urandom, 4'hF);
      ext_access(ADDR_W'(16'h0380 + 4 * i), 1'b0, $urandom, 4'hF);
    end
    stream_reads(8, 0);
  endtask

  task automatic back_pressure();
    stream_reads(3, 6);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    errors = 0;
    void'($urandom(50));
    rst_n         <= 1'b0;
    lsu_cmd_valid <= 1'b0;
    lsu_cmd_addr  <= '0;
    lsu_cmd_read  <= 1'b0;
    lsu_cmd_wdata <= '0;
    lsu_cmd_wmask <= '0;
    lsu_rsp_ready <= 1'b1;
    ext_cmd_valid <= 1'b0;
    ext_cmd_addr  <= '0;
    ext_cmd_read  <= 1'b0;
    ext_cmd_wdata <= '0;
    ext_cmd_wmask <= '0;
    ext_rsp_ready <= 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_reset_state();
    lsu_masked_rw();
    cross_port_rw();
    out_of_range();
    round_robin();
    back_pressure();
    repeat (2) @(posedge clk);
    $display("Checks complete with %0d error(s)", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- src.f
tcm_pkg.sv
tcm_if.sv
tcm_icb_arbiter.sv
tcm_ram_access.sv
tcm_sram.sv
tcm_rsp_buffer.sv
tcm_ctrl_top.sv
tb_tcm_ctrl.sv

//--- Bender.yml
package:
  name: tcm_ctrl

sources:
  - tcm_pkg.sv
  - tcm_if.sv
  - tcm_icb_arbiter.sv
  - tcm_ram_access.sv
  - tcm_sram.sv
  - tcm_rsp_buffer.sv
  - tcm_ctrl_top.sv
  - target: test
    files:
      - tb_tcm_ctrl.sv
